// File: hdl/flow_pkg.sv
`default_nettype none

package flow_pkg;

  // ----------------------------------------
  // Router dimensions
  // ----------------------------------------

  // Output flows fed by the demux
  localparam int num_flows = 4;

  // One beat of header or payload
  localparam int data_width = 32;

  // Width of a flow index
  localparam int flow_sel_width = $clog2(num_flows);

  // Payload length range is 0 to 15 beats
  localparam int beat_count_width = 4;

  // ----------------------------------------
  // Header layout
  // ----------------------------------------

  // Destination flow sits in the lowest bits
  localparam int hdr_dest_lsb = 0;

  // Payload length follows the destination
  localparam int hdr_len_lsb = 2;

  // ----------------------------------------
  // Types
  // ----------------------------------------

  typedef logic [data_width-1:0]       data_t;
  typedef logic [flow_sel_width-1:0]   flow_sel_t;
  typedef logic [beat_count_width-1:0] beat_count_t;

  // One bit per output flow, for valid and ready vectors
  typedef logic [num_flows-1:0] flow_mask_t;

  // Router FSM, waiting for a header or moving payload
  typedef enum logic {
    st_header  = 1'b0,
    st_payload = 1'b1
  } route_state_t;

endpackage : flow_pkg

`default_nettype wire

// File: hdl/flow_demux_select.sv
`timescale 1ns/10ps
`default_nettype none

module flow_demux_select (
  // Clock and reset only feed the protocol checks
  input  wire logic                                     clk,
  input  wire logic                                     rst_n,

  input  wire flow_pkg::flow_sel_t                      select,

  // Push side, one input flow
  output logic                                          push_ready,
  input  wire logic                                     push_valid,
  input  wire flow_pkg::data_t                          push_data,

  // Pop side, one flow per output
  input  wire flow_pkg::flow_mask_t                     pop_ready,
  output flow_pkg::flow_mask_t                          pop_valid,
  output flow_pkg::data_t [flow_pkg::num_flows-1:0]     pop_data
);

  import flow_pkg::*;

  // ----------------------------------------
  // Steering
  // ----------------------------------------

  // Input sees the ready of the selected flow only
  assign push_ready = pop_ready[select];

  // Valid goes to the selected flow, all others stay low
  assign pop_valid = flow_mask_t'(push_valid) << select;

  // Data fans out to every flow
  // Only the flow with valid high takes it
  always_comb begin
    for (int i = 0; i < num_flows; i++) begin
      pop_data[i] = push_data;
    end
  end

  // ----------------------------------------
  // Protocol checks
  // ----------------------------------------

  // A stalled beat keeps its route until it is taken
  a_select_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    (push_valid && !push_ready) |=> $stable(select)
  );

  // Upstream holds valid and data while stalled
  a_push_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    (push_valid && !push_ready) |=> (push_valid && $stable(push_data))
  );

endmodule : flow_demux_select

`default_nettype wire

// File: hdl/packet_route_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module packet_route_fsm (
  input  wire logic                  clk,
  input  wire logic                  rst_n,

  // Input handshake with ready from the demux
  input  wire logic                  in_valid,
  input  wire logic                  in_ready,
  input  wire flow_pkg::data_t       in_data,

  // Beat counter interface
  input  wire logic                  cnt_last,
  output logic                       cnt_load,
  output logic                       cnt_step,
  output flow_pkg::beat_count_t      load_len,

  // Demux select
  output flow_pkg::flow_sel_t        route_sel
);

  import flow_pkg::*;

  route_state_t state;
  flow_sel_t    dest_q;
  flow_sel_t    hdr_dest;
  beat_count_t  hdr_len;
  logic         in_xfer;

  // ----------------------------------------
  // Header decode
  // ----------------------------------------

  // Fields are only meaningful in st_header
  assign hdr_dest = in_data[hdr_dest_lsb +: $bits(flow_sel_t)];
  assign hdr_len  = in_data[hdr_len_lsb +: $bits(beat_count_t)];

  assign in_xfer = in_valid && in_ready;

  // Header beat routes on its own destination field
  // Payload uses the latched one, so payload bits cannot redirect
  assign route_sel = (state == st_header) ? hdr_dest : dest_q;

  // Counter strobes
  // Zero-length packets never load and the FSM stays put
  assign load_len = hdr_len;
  assign cnt_load = (state == st_header) && in_xfer && (hdr_len != '0);
  assign cnt_step = (state == st_payload) && in_xfer;

  // ----------------------------------------
  // State register
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= st_header;
      dest_q <= '0;
    end else begin
      case (state)
        st_header: begin
          if (in_xfer && (hdr_len != '0)) begin
            state  <= st_payload;
            dest_q <= hdr_dest;
          end
        end
        st_payload: begin
          // Leave on the last payload transfer
          if (in_xfer && cnt_last) begin
            state <= st_header;
          end
        end
        default: begin
          state <= st_header;
        end
      endcase
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // Counter only steps while payload is moving
  a_no_step_in_header : assert property (
    @(posedge clk) disable iff (!rst_n)
    cnt_step |-> (state == st_payload)
  );

endmodule : packet_route_fsm

`default_nettype wire

// File: hdl/beat_counter.sv
`timescale 1ns/10ps
`default_nettype none

module beat_counter (
  input  wire logic                  clk,
  input  wire logic                  rst_n,

  // Load with the packet's payload length
  input  wire logic                  load,
  input  wire flow_pkg::beat_count_t load_value,

  // One payload beat went through
  input  wire logic                  step,

  // One beat remains
  output logic                       last
);

  import flow_pkg::*;

  beat_count_t count;

  // ----------------------------------------
  // Remaining beats
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else if (load) begin
      count <= load_value;
    end else if (step) begin
      count <= count - beat_count_t'(1);
    end
  end

  // Next step is the final payload beat
  assign last = (count == beat_count_t'(1));

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // An empty counter never sees a payload beat
  a_no_step_at_zero : assert property (
    @(posedge clk) disable iff (!rst_n)
    step |-> (count != '0)
  );

  // Header and payload beats are distinct transfers
  a_no_load_and_step : assert property (
    @(posedge clk) disable iff (!rst_n)
    !(load && step)
  );

endmodule : beat_counter

`default_nettype wire

// File: hdl/flow_skid_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module flow_skid_buffer (
  input  wire logic            clk,
  input  wire logic            rst_n,

  // Push side from the demux
  input  wire logic            push_valid,
  output logic                 push_ready,
  input  wire flow_pkg::data_t push_data,

  // Registered pop side toward the output port
  output logic                 pop_valid,
  input  wire logic            pop_ready,
  output flow_pkg::data_t      pop_data
);

  import flow_pkg::*;

  // Second entry catches a beat when the output stalls
  logic  skid_valid;
  data_t skid_data;

  logic  push;
  logic  out_advance;

  assign push = push_valid && push_ready;

  // Output register can take a new beat this cycle
  assign out_advance = !pop_valid || pop_ready;

  // Ready comes straight from a flop
  // Low only while the skid entry holds a beat
  assign push_ready = !skid_valid;

  // ----------------------------------------
  // Valid bits
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pop_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      if (out_advance) begin
        pop_valid  <= skid_valid || push;
        skid_valid <= 1'b0;
      end else if (push) begin
        // Park the new beat while the output stalls
        skid_valid <= 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Data
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (out_advance) begin
      // Skid entry is older, so it goes first
      if (skid_valid) begin
        pop_data <= skid_data;
      end else if (push) begin
        pop_data <= push_data;
      end
    end
    if (push && !out_advance) begin
      skid_data <= push_data;
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // Never a third beat while both entries are full
  a_no_overflow : assert property (
    @(posedge clk) disable iff (!rst_n)
    (pop_valid && skid_valid) |-> !push
  );

endmodule : flow_skid_buffer

`default_nettype wire

// File: hdl/packet_router_top.sv
`timescale 1ns/10ps
`default_nettype none

module packet_router_top (
  input  wire logic                                   clk,
  input  wire logic                                   rst_n,

  // Input packet stream
  input  wire logic                                   in_valid,
  output logic                                        in_ready,
  input  wire flow_pkg::data_t                        in_data,

  // Output flows, indexed by destination
  output flow_pkg::flow_mask_t                        out_valid,
  input  wire flow_pkg::flow_mask_t                   out_ready,
  output flow_pkg::data_t [flow_pkg::num_flows-1:0]   out_data
);

  import flow_pkg::*;

  // FSM to demux and counter
  flow_sel_t   route_sel;
  logic        cnt_load;
  logic        cnt_step;
  logic        cnt_last;
  beat_count_t load_len;

  // Demux to skid buffers
  flow_mask_t                 buf_valid;
  flow_mask_t                 buf_ready;
  data_t [num_flows-1:0]      buf_data;

  // ----------------------------------------
  // Packet control
  // ----------------------------------------

  packet_route_fsm u_fsm (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .cnt_last  (cnt_last),
    .cnt_load  (cnt_load),
    .cnt_step  (cnt_step),
    .load_len  (load_len),
    .route_sel (route_sel)
  );

  beat_counter u_counter (
    .clk        (clk),
    .rst_n      (rst_n),
    .load       (cnt_load),
    .load_value (load_len),
    .step       (cnt_step),
    .last       (cnt_last)
  );

  // ----------------------------------------
  // Datapath
  // ----------------------------------------

  // Input ready follows the selected buffer only
  flow_demux_select u_demux (
    .clk        (clk),
    .rst_n      (rst_n),
    .select     (route_sel),
    .push_ready (in_ready),
    .push_valid (in_valid),
    .push_data  (in_data),
    .pop_ready  (buf_ready),
    .pop_valid  (buf_valid),
    .pop_data   (buf_data)
  );

  // One registered buffer per output flow
  for (genvar i = 0; i < num_flows; i++) begin : g_out_buf
    flow_skid_buffer u_buf (
      .clk        (clk),
      .rst_n      (rst_n),
      .push_valid (buf_valid[i]),
      .push_ready (buf_ready[i]),
      .push_data  (buf_data[i]),
      .pop_valid  (out_valid[i]),
      .pop_ready  (out_ready[i]),
      .pop_data   (out_data[i])
    );
  end

endmodule : packet_router_top

`default_nettype wire

// File: sim/packet_router_tb.sv
`timescale 1ns/10ps
`default_nettype none

module packet_router_tb;

  import flow_pkg::*;

  // 200 packets, up to 16 beats each, 8 cycles per beat at worst
  localparam int watchdog_ns = 200 * 16 * 8 * 10;

  logic                  clk;
  logic                  rst_n;
  logic                  in_valid;
  logic                  in_ready;
  data_t                 in_data;
  flow_mask_t            out_valid;
  flow_mask_t            out_ready;
  data_t [num_flows-1:0] out_data;

  integer      seed;
  logic        burst_mode;
  // Expected beats, one queue per output flow
  data_t       exp_q [num_flows][$];
  flow_sel_t   mon_flow;
  beat_count_t mon_left;
  int          stalls;

  packet_router_top dut (.*);

  // ----------------------------------------
  // Reference and checks
  // ----------------------------------------

  // Destination sits in header bits 1:0
  function automatic flow_sel_t expected_flow(input data_t hdr);
    return hdr[1:0];
  endfunction

  // Payload length sits in header bits 5:2
  function automatic beat_count_t expected_len(input data_t hdr);
    return hdr[5:2];
  endfunction

  function automatic bit queues_empty();
    for (int f = 0; f < num_flows; f++) begin
      if (exp_q[f].size() != 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "Run stopped at %0t", $time);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s actual %h expected %h", $time, name, actual, expected);
      fail_run("Value check failed");
    end
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  // One beat, optional idle gap first; counts cycles lost to back-pressure
  task automatic send_beat(input data_t beat, input bit allow_gap, inout int stall);
    int gap;
    gap = 0;
    if (allow_gap && (($random(seed) & 3) == 0)) gap = 1 + ($random(seed) & 3);
    repeat (gap) begin
      in_valid <= 1'b0;
      @(posedge clk);
    end
    in_valid <= 1'b1;
    in_data  <= beat;
    @(posedge clk);
    while (!in_ready) begin
      stall++;
      @(posedge clk);
    end
  endtask

  task automatic send_packet(input int index, input bit allow_gap, inout int stall);
    flow_sel_t   dest;
    beat_count_t len;
    data_t       word;
    dest = flow_sel_t'($random(seed));
    len  = beat_count_t'($random(seed));
    // Force header-only and maximum-length packets now and then
    if (index % 10 == 0) len = '0;
    if (index % 10 == 5) len = 4'd15;
    word      = $random(seed);
    word[1:0] = dest;
    word[5:2] = len;
    send_beat(word, allow_gap, stall);
    for (int b = 0; b < len; b++) begin
      word = $random(seed);
      // Even payload words mimic a header aimed elsewhere
      if (b % 2 == 0) word[1:0] = dest + 2'd1;
      send_beat(word, allow_gap, stall);
    end
  endtask

  // Bounded wait for the scoreboard to empty
  task automatic wait_for_drain(input int max_cycles);
    int n;
    n = 0;
    @(negedge clk);
    while (!queues_empty() && (n < max_cycles)) begin
      n++;
      @(negedge clk);
    end
  endtask

  // ----------------------------------------
  // Processes
  // ----------------------------------------

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    fail_run("Timeout: the run did not finish in the expected time");
  end

  // Random back-pressure per flow, all ready during the burst phase
  always @(posedge clk) begin
    if (burst_mode) out_ready <= '1;
    else if (rst_n) out_ready <= flow_mask_t'($random(seed));
  end

  // Input monitor, tracks packet boundaries from the headers
  always @(posedge clk) begin
    if (rst_n && in_valid && in_ready) begin
      if (mon_left == '0) begin
        mon_flow = expected_flow(in_data);
        mon_left = expected_len(in_data);
      end else begin
        mon_left = mon_left - 4'd1;
      end
      exp_q[mon_flow].push_back(in_data);
    end
  end

  // Output compare on every handshake
  always @(posedge clk) begin
    if (rst_n) begin
      for (int f = 0; f < num_flows; f++) begin
        if (out_valid[f] && out_ready[f]) begin
          if (exp_q[f].size() == 0) begin
            fail_run($sformatf("Unexpected beat %h on flow %0d", out_data[f], f));
          end else begin
            check_value($sformatf("out_data[%0d]", f), out_data[f], exp_q[f].pop_front());
          end
        end
      end
    end
  end

  initial begin
    seed       = 32'h75e5_9933;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_data    = '0;
    out_ready  = '0;
    burst_mode = 1'b0;
    mon_flow   = '0;
    mon_left   = '0;
    stalls     = 0;
    // Reset held for 4 cycles, outputs idle throughout
    @(posedge clk);
    repeat (3) begin
      @(posedge clk);
      check_value("out_valid", out_valid, '0);
    end
    rst_n <= 1'b1;
    @(posedge clk);
    check_value("in_ready", in_ready, 1'b1);
    check_value("out_valid", out_valid, '0);
    // Random gaps and back-pressure
    for (int p = 0; p < 160; p++) send_packet(p, 1'b1, stalls);
    in_valid   <= 1'b0;
    burst_mode <= 1'b1;
    wait_for_drain(200);
    if (!queues_empty()) fail_run("Beats lost before the burst phase");
    // Back-to-back packets with every output ready, no stall allowed
    @(posedge clk);
    for (int p = 160; p < 200; p++) begin
      stalls = 0;
      send_packet(p, 1'b0, stalls);
      check_value("burst stall cycles", stalls, 0);
    end
    in_valid <= 1'b0;
    wait_for_drain(200);
    @(negedge clk);
    check_value("out_valid", out_valid, '0);
    if (queues_empty()) begin
      $display("** PASS **");
      $finish;
    end else begin
      fail_run("Beats still missing at the end of the run");
    end
  end

endmodule : packet_router_tb

`default_nettype wire

// File: flist.f
hdl/flow_pkg.sv
hdl/flow_demux_select.sv
hdl/packet_route_fsm.sv
hdl/beat_counter.sv
hdl/flow_skid_buffer.sv
hdl/packet_router_top.sv
sim/packet_router_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the packet router testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --timescale 1ns/10ps \
  --top-module packet_router_tb \
  -f flist.f \
  -o packet_router_sim \
  && ./obj_dir/packet_router_sim \
  || { echo "Simulation did not pass"; exit 1; }
